// File: Bender.yml
package:
  name: commit_trace

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/trace_pkg.sv
      - hw/commit_if.sv
      - hw/commit_classify.sv
      - hw/pc_queue.sv
      - hw/pc_arbiter.sv
      - hw/perf_counters.sv
      - hw/commit_trace_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/commit_trace_sva.sv
      - testbench/tb_checker.sv
      - testbench/tb_top.sv

// File: flist.f
+incdir+hw
hw/core_pkg.sv
hw/trace_pkg.sv
hw/commit_if.sv
hw/commit_classify.sv
hw/pc_queue.sv
hw/pc_arbiter.sv
hw/perf_counters.sv
hw/commit_trace_top.sv
testbench/commit_trace_sva.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: hw/commit_classify.sv
`default_nettype none

`include "trace_config.svh"

module commit_classify (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  commit_if.sink                commit_i,
  output trace_pkg::trace_rec_t trace_o [`NR_COMMIT_PORTS]
);

  trace_pkg::mode_t mode;

  // Debug mode hides the privilege level
  always_comb begin
    if (commit_i.debug_mode) begin
      mode = trace_pkg::MODE_D;
    end else begin
      case (commit_i.priv_lvl)
        core_pkg::PRIV_LVL_U: mode = trace_pkg::MODE_U;
        core_pkg::PRIV_LVL_S: mode = trace_pkg::MODE_S;
        // reserved level reported as machine mode
        default:              mode = trace_pkg::MODE_M;
      endcase
    end
  end

  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_port
    logic               is_irq;
    logic               valid_q, exception_q, interrupt_q;
    logic [`VLEN-1:0]   iaddr_q;
    logic [`INSN_W-1:0] insn_q;
    logic [`XLEN-1:0]   cause_q;
    trace_pkg::mode_t   mode_q;

    assign is_irq = commit_i.entry[i].cause[core_pkg::CAUSE_IRQ_BIT];

    // Flags, zero in every cycle without a commit
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q     <= 1'b0;
        exception_q <= 1'b0;
        interrupt_q <= 1'b0;
      end else begin
        valid_q     <= commit_i.ack[i] & ~commit_i.entry[i].ex_valid;
        exception_q <= commit_i.ack[i] & commit_i.entry[i].ex_valid & ~is_irq;
        interrupt_q <= commit_i.ack[i] & commit_i.entry[i].ex_valid & is_irq;
      end
    end

    // Record payload
    always_ff @(posedge clk_i) begin
      iaddr_q <= commit_i.entry[i].pc;
      insn_q  <= commit_i.entry[i].insn;
      cause_q <= commit_i.entry[i].cause;
      mode_q  <= mode;
    end

    assign trace_o[i] = '{valid:     valid_q,
                          exception: exception_q,
                          interrupt: interrupt_q,
                          iaddr:     iaddr_q,
                          insn:      insn_q,
                          cause:     cause_q,
                          mode:      mode_q};
  end

endmodule

`default_nettype wire

// File: hw/commit_if.sv
`default_nettype none

`include "trace_config.svh"

interface commit_if;

  // Per port commit strobe and the committed entry
  logic                    ack   [`NR_COMMIT_PORTS];
  core_pkg::commit_entry_t entry [`NR_COMMIT_PORTS];

  // Shared by all ports in a cycle
  core_pkg::priv_lvl_t     priv_lvl;
  logic                    debug_mode;

  // Full view, for classification and event counting
  modport sink (
    input ack,
    input entry,
    input priv_lvl,
    input debug_mode
  );

  // PC queues only need the strobe, the exception bit and the PC
  modport pc_push (
    input ack,
    input entry
  );

endinterface

`default_nettype wire

// File: hw/commit_trace_top.sv
`default_nettype none

`include "trace_config.svh"

module commit_trace_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Commit ports
  input  logic                             commit_ack_i      [`NR_COMMIT_PORTS],
  input  logic                             commit_ex_valid_i [`NR_COMMIT_PORTS],
  input  logic [`VLEN-1:0]                 commit_pc_i       [`NR_COMMIT_PORTS],
  input  logic [`INSN_W-1:0]               commit_insn_i     [`NR_COMMIT_PORTS],
  input  logic [`XLEN-1:0]                 commit_cause_i    [`NR_COMMIT_PORTS],
  input  core_pkg::priv_lvl_t              priv_lvl_i,
  input  logic                             debug_mode_i,
  // Trace records
  output logic                             trace_valid_o     [`NR_COMMIT_PORTS],
  output logic                             trace_exception_o [`NR_COMMIT_PORTS],
  output logic                             trace_interrupt_o [`NR_COMMIT_PORTS],
  output logic [`VLEN-1:0]                 trace_iaddr_o     [`NR_COMMIT_PORTS],
  output logic [`INSN_W-1:0]               trace_insn_o      [`NR_COMMIT_PORTS],
  output logic [`XLEN-1:0]                 trace_cause_o     [`NR_COMMIT_PORTS],
  output trace_pkg::mode_t                 trace_mode_o      [`NR_COMMIT_PORTS],
  // Serial PC stream
  output logic                             pc_valid_o,
  output logic [`VLEN-1:0]                 pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0] pc_port_o,
  output logic                             pc_overflow_o,
  // Counter read port
  input  trace_pkg::perf_sel_t             perf_addr_i,
  input  logic                             perf_clear_i,
  output logic [`PERF_CNT_W-1:0]           perf_rdata_o
);

  commit_if commit_bus ();

  trace_pkg::trace_rec_t       trace      [`NR_COMMIT_PORTS];
  logic                        q_empty    [`NR_COMMIT_PORTS];
  logic [`VLEN-1:0]            q_head     [`NR_COMMIT_PORTS];
  logic                        q_pop      [`NR_COMMIT_PORTS];
  logic [`NR_COMMIT_PORTS-1:0] q_overflow;

  // ----------------------------------------------------------------------------
  // Commit bus and trace unpacking
  // ----------------------------------------------------------------------------

  assign commit_bus.priv_lvl   = priv_lvl_i;
  assign commit_bus.debug_mode = debug_mode_i;

  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_port
    assign commit_bus.ack[i]   = commit_ack_i[i];
    assign commit_bus.entry[i] = '{pc:       commit_pc_i[i],
                                   insn:     commit_insn_i[i],
                                   cause:    commit_cause_i[i],
                                   ex_valid: commit_ex_valid_i[i]};

    assign trace_valid_o[i]     = trace[i].valid;
    assign trace_exception_o[i] = trace[i].exception;
    assign trace_interrupt_o[i] = trace[i].interrupt;
    assign trace_iaddr_o[i]     = trace[i].iaddr;
    assign trace_insn_o[i]      = trace[i].insn;
    assign trace_cause_o[i]     = trace[i].cause;
    assign trace_mode_o[i]      = trace[i].mode;

    pc_queue #(
      .PORT ( i )
    ) i_pc_queue (
      .clk_i      ( clk_i                 ),
      .rst_ni     ( rst_ni                ),
      .push_i     ( commit_bus.pc_push    ),
      .pop_i      ( q_pop[i]              ),
      .empty_o    ( q_empty[i]            ),
      .head_o     ( q_head[i]             ),
      .overflow_o ( q_overflow[i]         )
    );
  end

  assign pc_overflow_o = |q_overflow;

  // ----------------------------------------------------------------------------
  // Classification, PC stream and counters
  // ----------------------------------------------------------------------------

  commit_classify i_commit_classify (
    .clk_i    ( clk_i           ),
    .rst_ni   ( rst_ni          ),
    .commit_i ( commit_bus.sink ),
    .trace_o  ( trace           )
  );

  pc_arbiter i_pc_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( q_empty    ),
    .head_i     ( q_head     ),
    .pop_o      ( q_pop      ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       ),
    .pc_port_o  ( pc_port_o  )
  );

  perf_counters i_perf_counters (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .commit_i     ( commit_bus.sink ),
    .perf_addr_i  ( perf_addr_i     ),
    .perf_clear_i ( perf_clear_i    ),
    .perf_rdata_o ( perf_rdata_o    )
  );

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

`include "trace_config.svh"

package core_pkg;

  // Privilege levels, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // Top bit of the cause tells an interrupt from an exception
  localparam int unsigned CAUSE_IRQ_BIT = `XLEN - 1;

  // One instruction leaving the commit stage
  typedef struct packed {
    logic [`VLEN-1:0]   pc;
    logic [`INSN_W-1:0] insn;
    logic [`XLEN-1:0]   cause;
    logic               ex_valid;
  } commit_entry_t;

endpackage

`default_nettype wire

// File: hw/pc_arbiter.sv
`default_nettype none

`include "trace_config.svh"

module pc_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                empty_i [`NR_COMMIT_PORTS],
  input  logic [`VLEN-1:0]                    head_i  [`NR_COMMIT_PORTS],
  output logic                                pop_o   [`NR_COMMIT_PORTS],
  output logic                                pc_valid_o,
  output logic [`VLEN-1:0]                    pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]    pc_port_o
);

  localparam int unsigned N     = `NR_COMMIT_PORTS;
  localparam int unsigned IDX_W = trace_pkg::PORT_IDX_W;

  logic [IDX_W-1:0] last_q, grant_idx;
  logic             any_req;

  // Search starts one past the last grant and wraps around
  always_comb begin
    int unsigned cand;
    any_req   = 1'b0;
    grant_idx = last_q;
    for (int unsigned k = 1; k <= N; k++) begin
      cand = (int'(last_q) + k) % N;
      if (!any_req && !empty_i[cand]) begin
        any_req   = 1'b1;
        grant_idx = IDX_W'(cand);
      end
    end
    for (int unsigned p = 0; p < N; p++) begin
      pop_o[p] = any_req && (grant_idx == IDX_W'(p));
    end
  end

  // Port 0 wins first after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q     <= IDX_W'(N - 1);
      pc_valid_o <= 1'b0;
    end else begin
      pc_valid_o <= any_req;
      if (any_req) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_req) begin
      pc_o      <= head_i[grant_idx];
      pc_port_o <= grant_idx;
    end
  end

endmodule

`default_nettype wire

// File: hw/pc_queue.sv
`default_nettype none

`include "trace_config.svh"

module pc_queue #(
  parameter int unsigned PORT = 0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  commit_if.pc_push        push_i,
  input  logic             pop_i,
  output logic             empty_o,
  output logic [`VLEN-1:0] head_o,
  output logic             overflow_o
);

  localparam int unsigned DEPTH = `PC_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [`VLEN-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push, full, do_push, do_pop;

  // Only clean retirements enter the queue
  assign push    = push_i.ack[PORT] & ~push_i.entry[PORT].ex_valid;
  assign full    = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i & ~empty_o;
  // A full queue still accepts when the head leaves this cycle
  assign do_push = push & (~full | do_pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Dropped entry, flag stays until reset
      if (push && !do_push) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_i.entry[PORT].pc;
    end
  end

  assign head_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: hw/perf_counters.sv
`default_nettype none

`include "trace_config.svh"

module perf_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  commit_if.sink                  commit_i,
  input  trace_pkg::perf_sel_t    perf_addr_i,
  input  logic                    perf_clear_i,
  output logic [`PERF_CNT_W-1:0]  perf_rdata_o
);

  localparam int unsigned NR_CNT = 2 ** $bits(trace_pkg::perf_sel_t);
  // Enough for every port reporting the same event
  localparam int unsigned INC_W  = $clog2(`NR_COMMIT_PORTS + 1);

  logic [`PERF_CNT_W-1:0] cnt_q [NR_CNT];
  logic [INC_W-1:0]       inc   [NR_CNT];

  // ----------------------------------------------------------------------------
  // Per cycle increments
  // ----------------------------------------------------------------------------

  always_comb begin
    inc = '{default: '0};
    inc[trace_pkg::PERF_CYCLES] = INC_W'(1);
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      if (commit_i.ack[p]) begin
        if (!commit_i.entry[p].ex_valid) begin
          inc[trace_pkg::PERF_RETIRED] = inc[trace_pkg::PERF_RETIRED] + 1'b1;
        end else if (commit_i.entry[p].cause[core_pkg::CAUSE_IRQ_BIT]) begin
          inc[trace_pkg::PERF_INTERRUPTS] = inc[trace_pkg::PERF_INTERRUPTS] + 1'b1;
        end else begin
          inc[trace_pkg::PERF_EXCEPTIONS] = inc[trace_pkg::PERF_EXCEPTIONS] + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------------
  // Counters
  // ----------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < NR_CNT; k++) begin
        cnt_q[k] <= '0;
      end
    end else if (perf_clear_i) begin
      // Clear beats any increment in the same cycle
      for (int k = 0; k < NR_CNT; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NR_CNT; k++) begin
        cnt_q[k] <= cnt_q[k] + `PERF_CNT_W'(inc[k]);
      end
    end
  end

  // Read port
  assign perf_rdata_o = cnt_q[perf_addr_i];

endmodule

`default_nettype wire

// File: hw/trace_config.svh
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// ----------------------------------------------------------------------------
// Commit trace configuration
// ----------------------------------------------------------------------------

// Commit ports observed per cycle
`define NR_COMMIT_PORTS 2

// Data and cause width
`define XLEN 64
// Virtual address width of a PC
`define VLEN 64
// Instruction word width
`define INSN_W 32

// Entries in each retired-PC queue
`define PC_QUEUE_DEPTH 8
// Width of every performance counter
`define PERF_CNT_W 64

`endif

// File: hw/trace_pkg.sv
`default_nettype none

`include "trace_config.svh"

package trace_pkg;

  // Mode tag of a record, debug takes the reserved privilege code
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_D = 2'b10,
    MODE_M = 2'b11
  } mode_t;

  // One record per commit port and cycle
  typedef struct packed {
    logic               valid;
    logic               exception;
    logic               interrupt;
    logic [`VLEN-1:0]   iaddr;
    logic [`INSN_W-1:0] insn;
    logic [`XLEN-1:0]   cause;
    mode_t              mode;
  } trace_rec_t;

  // Counter index on the read port
  typedef enum logic [1:0] {
    PERF_CYCLES     = 2'd0,
    PERF_RETIRED    = 2'd1,
    PERF_EXCEPTIONS = 2'd2,
    PERF_INTERRUPTS = 2'd3
  } perf_sel_t;

  // Width of the port tag on the serial PC stream
  localparam int unsigned PORT_IDX_W = (`NR_COMMIT_PORTS > 1) ? $clog2(`NR_COMMIT_PORTS) : 1;

endpackage

`default_nettype wire

// File: testbench/commit_trace_sva.sv
`default_nettype none

`include "trace_config.svh"

module commit_trace_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic valid_i     [`NR_COMMIT_PORTS],
  input logic exception_i [`NR_COMMIT_PORTS],
  input logic interrupt_i [`NR_COMMIT_PORTS],
  input logic empty_i     [`NR_COMMIT_PORTS],
  input logic pc_valid_i,
  input logic overflow_i
);

  int unsigned                 fail_cnt = 0;
  logic [`NR_COMMIT_PORTS-1:0] empty_vec;

  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_port
    assign empty_vec[i] = empty_i[i];

    // At most one classification per record
    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({valid_i[i], exception_i[i], interrupt_i[i]}))
      else begin
        fail_cnt++;
        $error("trace flags of port %0d are not exclusive", i);
      end
  end

  // Nothing to drain means no PC next cycle
  no_pc_from_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&empty_vec) |=> !pc_valid_i)
    else begin
      fail_cnt++;
      $error("PC stream pulsed although every queue was empty");
    end

  overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    overflow_i |=> overflow_i)
    else begin
      fail_cnt++;
      $error("queue overflow flag dropped outside reset");
    end

endmodule

bind commit_trace_top commit_trace_sva i_sva (
  .clk_i       ( clk_i             ),
  .rst_ni      ( rst_ni            ),
  .valid_i     ( trace_valid_o     ),
  .exception_i ( trace_exception_o ),
  .interrupt_i ( trace_interrupt_o ),
  .empty_i     ( q_empty           ),
  .pc_valid_i  ( pc_valid_o        ),
  .overflow_i  ( pc_overflow_o     )
);

`default_nettype wire

// File: testbench/tb_checker.sv
`default_nettype none

`include "trace_config.svh"

module tb_checker (
  input logic clk_i,
  input logic rst_ni
);

  localparam int NP = `NR_COMMIT_PORTS;

  string              test_name = "reset";
  int                 err_cnt = 0;
  int                 test_err_start = 0;
  int                 n_tests = 0;
  int                 n_failed = 0;
  bit                 pc_check_en = 1'b0;

  // Expected PCs per port, oldest first
  logic [`VLEN-1:0]   exp_pc [NP][$];
  longint unsigned    cnt_model [4];

  // Inputs seen one cycle earlier
  bit                 prev_ok;
  bit                 prev_ovf;
  logic               prev_ack [NP];
  logic               prev_ex [NP];
  logic [`VLEN-1:0]   prev_pc [NP];
  logic [`INSN_W-1:0] prev_insn [NP];
  logic [`XLEN-1:0]   prev_cause [NP];
  logic [1:0]         prev_priv;
  logic               prev_dbg;

  // --------------------------------------------------------------------------
  // Reporting
  // --------------------------------------------------------------------------

  task automatic report_text(input string msg);
    err_cnt++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  task automatic compare(input string what, input logic [127:0] exp, input logic [127:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    int n;
    n = err_cnt - test_err_start;
    n_tests++;
    if (n == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", test_name, n);
    end
  endtask

  // --------------------------------------------------------------------------
  // Model
  // --------------------------------------------------------------------------

  task automatic reset_model();
    for (int p = 0; p < NP; p++) begin
      exp_pc[p].delete();
      prev_ack[p] = 1'b0;
    end
    for (int k = 0; k < 4; k++) begin
      cnt_model[k] = 0;
    end
    prev_ok  = 1'b0;
    prev_ovf = 1'b0;
  endtask

  task automatic check_trace();
    logic       irq;
    logic [1:0] exp_mode;
    // Debug takes the reserved code 2
    exp_mode = prev_dbg ? 2'd2 : (prev_priv == 2'd0) ? 2'd0 : (prev_priv == 2'd1) ? 2'd1 : 2'd3;
    for (int p = 0; p < NP; p++) begin
      irq = prev_cause[p][`XLEN-1];
      compare($sformatf("port %0d valid", p), prev_ack[p] && !prev_ex[p],
              tb_top.dut.trace_valid_o[p]);
      compare($sformatf("port %0d exception", p), prev_ack[p] && prev_ex[p] && !irq,
              tb_top.dut.trace_exception_o[p]);
      compare($sformatf("port %0d interrupt", p), prev_ack[p] && prev_ex[p] && irq,
              tb_top.dut.trace_interrupt_o[p]);
      if (prev_ack[p]) begin
        compare($sformatf("port %0d iaddr", p), prev_pc[p], tb_top.dut.trace_iaddr_o[p]);
        compare($sformatf("port %0d insn", p), prev_insn[p], tb_top.dut.trace_insn_o[p]);
        compare($sformatf("port %0d cause", p), prev_cause[p], tb_top.dut.trace_cause_o[p]);
      end
      if (prev_ok) begin
        compare($sformatf("port %0d mode", p), exp_mode, tb_top.dut.trace_mode_o[p]);
      end
    end
  endtask

  task automatic check_pc_stream();
    int port;
    port = tb_top.dut.pc_port_o;
    if (pc_check_en && tb_top.dut.pc_valid_o) begin
      if (exp_pc[port].size() == 0) begin
        report_text($sformatf("PC %0h on port %0d without a pending retirement",
                              tb_top.dut.pc_o, port));
      end else begin
        compare($sformatf("port %0d pc", port), exp_pc[port].pop_front(), tb_top.dut.pc_o);
      end
    end
    if (prev_ovf && !tb_top.dut.pc_overflow_o) begin
      report_text("overflow flag cleared without a reset");
    end
    prev_ovf = tb_top.dut.pc_overflow_o;
  endtask

  task automatic sample_inputs();
    for (int p = 0; p < NP; p++) begin
      prev_ack[p]   = tb_top.commit_ack_i[p];
      prev_ex[p]    = tb_top.commit_ex_valid_i[p];
      prev_pc[p]    = tb_top.commit_pc_i[p];
      prev_insn[p]  = tb_top.commit_insn_i[p];
      prev_cause[p] = tb_top.commit_cause_i[p];
      if (pc_check_en && prev_ack[p] && !prev_ex[p]) begin
        exp_pc[p].push_back(prev_pc[p]);
      end
    end
    // Clear beats the increments of the same cycle
    if (tb_top.perf_clear_i) begin
      for (int k = 1; k < 4; k++) begin
        cnt_model[k] = 0;
      end
    end else begin
      for (int p = 0; p < NP; p++) begin
        if (prev_ack[p]) begin
          // Index 1 retired, 2 exceptions, 3 interrupts
          cnt_model[!prev_ex[p] ? 1 : prev_cause[p][`XLEN-1] ? 3 : 2]++;
        end
      end
    end
    prev_priv = tb_top.priv_lvl_i;
    prev_dbg  = tb_top.debug_mode_i;
    prev_ok   = 1'b1;
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      check_trace();
      check_pc_stream();
      sample_inputs();
    end
  end

  // --------------------------------------------------------------------------
  // Checks called from the test sequence
  // --------------------------------------------------------------------------

  function automatic int pc_pending();
    int n = 0;
    for (int p = 0; p < NP; p++) begin
      n += exp_pc[p].size();
    end
    return n;
  endfunction

  task automatic check_drained();
    if (pc_pending() != 0) begin
      report_text($sformatf("%0d retired PCs never reached the PC stream", pc_pending()));
    end
  endtask

  task automatic expect_overflow(input logic exp);
    compare("pc_overflow_o", exp, tb_top.dut.pc_overflow_o);
  endtask

  task automatic check_counter(input int sel, input longint unsigned min_cycles);
    if (sel == 0) begin
      if (tb_top.dut.perf_rdata_o < min_cycles) begin
        report_text($sformatf("cycle counter %0d is below %0d stimulus cycles",
                              tb_top.dut.perf_rdata_o, min_cycles));
      end
    end else begin
      compare($sformatf("counter %0d", sel), cnt_model[sel], tb_top.dut.perf_rdata_o);
    end
  endtask

  task automatic check_zero(input int sel);
    compare($sformatf("counter %0d after clear", sel), '0, tb_top.dut.perf_rdata_o);
  endtask

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`default_nettype none

`include "trace_config.svh"

module tb_top;

  localparam int NP       = `NR_COMMIT_PORTS;
  localparam int K_RANDOM = 0;
  localparam int K_SPARSE = 1;
  localparam int K_FULL   = 2;
  localparam int K_IDLE   = 3;

  integer seed = 32'h461e_67f5;

  logic                             clk_i, rst_ni;
  logic                             commit_ack_i [NP], commit_ex_valid_i [NP];
  logic [`VLEN-1:0]                 commit_pc_i [NP];
  logic [`INSN_W-1:0]               commit_insn_i [NP];
  logic [`XLEN-1:0]                 commit_cause_i [NP];
  core_pkg::priv_lvl_t              priv_lvl_i;
  logic                             debug_mode_i;
  logic                             trace_valid_o [NP], trace_exception_o [NP];
  logic                             trace_interrupt_o [NP];
  logic [`VLEN-1:0]                 trace_iaddr_o [NP];
  logic [`INSN_W-1:0]               trace_insn_o [NP];
  logic [`XLEN-1:0]                 trace_cause_o [NP];
  trace_pkg::mode_t                 trace_mode_o [NP];
  logic                             pc_valid_o, pc_overflow_o;
  logic [`VLEN-1:0]                 pc_o;
  logic [trace_pkg::PORT_IDX_W-1:0] pc_port_o;
  trace_pkg::perf_sel_t             perf_addr_i;
  logic                             perf_clear_i;
  logic [`PERF_CNT_W-1:0]           perf_rdata_o;

  commit_trace_top dut (.*);

  tb_checker chk (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // One cycle of commits, kind picks the traffic pattern
  task automatic drive_cycle(input int kind, input int cyc, input bit rand_mode);
    int sel;
    @(posedge clk_i);
    sel = ($random(seed) & 32'h7fff_ffff) % NP;
    for (int p = 0; p < NP; p++) begin
      case (kind)
        K_RANDOM: commit_ack_i[p] <= ($random(seed) & 1) != 0;
        // Sparse: one port at most, every other cycle
        K_SPARSE: commit_ack_i[p] <= (cyc % 2 == 0) && (p == sel) && (($random(seed) & 1) != 0);
        K_FULL:   commit_ack_i[p] <= 1'b1;
        default:  commit_ack_i[p] <= 1'b0;
      endcase
      commit_ex_valid_i[p] <= (kind != K_FULL) && (($random(seed) & 3) == 0);
      commit_pc_i[p]       <= {$random(seed), $random(seed)};
      commit_insn_i[p]     <= $random(seed);
      commit_cause_i[p]    <= {$random(seed), $random(seed)};
    end
    if (rand_mode) begin
      sel = ($random(seed) & 32'h7fff_ffff) % 3;
      priv_lvl_i   <= (sel == 0) ? core_pkg::PRIV_LVL_U :
                      (sel == 1) ? core_pkg::PRIV_LVL_S : core_pkg::PRIV_LVL_M;
      debug_mode_i <= ($random(seed) & 3) == 0;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    rst_ni       = 1'b0;
    priv_lvl_i   = core_pkg::PRIV_LVL_M;
    debug_mode_i = 1'b0;
    perf_addr_i  = trace_pkg::PERF_CYCLES;
    perf_clear_i = 1'b0;
    for (int p = 0; p < NP; p++) begin
      commit_ack_i[p]      = 1'b0;
      commit_ex_valid_i[p] = 1'b0;
      commit_pc_i[p]       = '0;
      commit_insn_i[p]     = '0;
      commit_cause_i[p]    = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    chk.begin_test("classify");
    for (int c = 0; c < 200; c++) drive_cycle(K_RANDOM, c, 1'b0);
    repeat (2) drive_cycle(K_IDLE, 0, 1'b0);
    chk.end_test();

    chk.begin_test("mode");
    for (int c = 0; c < 150; c++) drive_cycle(K_RANDOM, c, 1'b1);
    repeat (2) drive_cycle(K_IDLE, 0, 1'b0);
    chk.end_test();

    apply_reset();
    chk.begin_test("pc_stream");
    chk.pc_check_en = 1'b1;
    for (int c = 0; c < 200; c++) drive_cycle(K_SPARSE, c, 1'b0);
    drive_cycle(K_IDLE, 0, 1'b0);
    // Drain with its own timeout
    for (int t = 0; t < 100 && chk.pc_pending() != 0; t++) @(negedge clk_i);
    chk.check_drained();
    chk.expect_overflow(1'b0);
    chk.pc_check_en = 1'b0;
    chk.end_test();

    apply_reset();
    chk.begin_test("counters");
    for (int c = 0; c < 150; c++) drive_cycle(K_RANDOM, c, 1'b0);
    repeat (2) drive_cycle(K_IDLE, 0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      @(posedge clk_i);
      perf_addr_i <= trace_pkg::perf_sel_t'(k);
      @(negedge clk_i);
      chk.check_counter(k, 150);
    end
    @(posedge clk_i);
    perf_clear_i <= 1'b1;
    perf_addr_i  <= trace_pkg::PERF_CYCLES;
    @(posedge clk_i);
    perf_clear_i <= 1'b0;
    @(negedge clk_i);
    chk.check_zero(0);
    for (int k = 1; k < 4; k++) begin
      @(posedge clk_i);
      perf_addr_i <= trace_pkg::perf_sel_t'(k);
      @(negedge clk_i);
      chk.check_zero(k);
    end
    chk.end_test();

    apply_reset();
    chk.begin_test("overflow");
    for (int c = 0; c < 40; c++) drive_cycle(K_FULL, c, 1'b0);
    @(negedge clk_i);
    chk.expect_overflow(1'b1);
    repeat (10) drive_cycle(K_IDLE, 0, 1'b0);
    @(negedge clk_i);
    chk.expect_overflow(1'b1);
    chk.end_test();

    $display("tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             chk.n_tests, chk.n_failed, chk.err_cnt, dut.i_sva.fail_cnt);
    if (chk.err_cnt == 0 && dut.i_sva.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
